// File: include/lsu_defines.svh
`ifndef LSU_DEFINES_SVH
`define LSU_DEFINES_SVH

// data path and address width
`define LSU_DATA_W 32

// register number width, 32 architectural registers
`define LSU_RF_ADDR_W 5

// data RAM word address width, 1024 words of 4 bytes
`define LSU_RAM_ADDR_W 10

// one strobe bit per byte lane
`define LSU_STRB_W (`LSU_DATA_W / 8)

// number of words in the data RAM
`define LSU_RAM_DEPTH (1 << `LSU_RAM_ADDR_W)

`endif

// File: rtl/lsu_pkg.sv
`include "lsu_defines.svh"

package lsu_pkg;

    typedef logic [`LSU_DATA_W-1:0]     word_t;
    typedef logic [`LSU_RF_ADDR_W-1:0]  rf_addr_t;
    typedef logic [`LSU_RAM_ADDR_W-1:0] ram_addr_t;
    typedef logic [`LSU_STRB_W-1:0]     strb_t;

    // memory operation carried down from execute
    typedef enum logic [3:0] {
        op_none,
        op_ld_w,
        op_ld_b,
        op_ld_bu,
        op_ld_h,
        op_ld_hu,
        op_st_w,
        op_st_b,
        op_st_h
    } mem_op_t;

    function automatic logic op_is_load(mem_op_t op);
        return (op == op_ld_w) || (op == op_ld_b) || (op == op_ld_bu) ||
               (op == op_ld_h) || (op == op_ld_hu);
    endfunction

    function automatic logic op_is_store(mem_op_t op);
        return (op == op_st_w) || (op == op_st_b) || (op == op_st_h);
    endfunction

endpackage

// File: rtl/store_unit.sv
`timescale 1ns/1ps
`include "lsu_defines.svh"

module store_unit
    import lsu_pkg::*;
(
    input  logic      ex_accept,
    input  word_t     ex_result,
    input  word_t     ex_store_data,
    input  mem_op_t   ex_mem_op,
    output logic      ram_en,
    output logic      ram_we,
    output ram_addr_t ram_addr,
    output strb_t     ram_strb,
    output word_t     ram_wdata
);

    logic [1:0] byte_off;

    assign byte_off = ex_result[1:0];

    // RAM is touched only for an accepted load or store
    assign ram_en   = ex_accept & (op_is_load(ex_mem_op) | op_is_store(ex_mem_op));
    assign ram_we   = ex_accept & op_is_store(ex_mem_op);
    assign ram_addr = ex_result[`LSU_RAM_ADDR_W+1:2];

    always_comb begin
        case (ex_mem_op)
            op_st_w: ram_strb = 4'b1111;
            op_st_h: ram_strb = byte_off[1] ? 4'b1100 : 4'b0011;
            op_st_b: ram_strb = 4'b0001 << byte_off;
            default: ram_strb = 4'b0000;
        endcase
    end

    // replicate sub-word data so the strobes pick the right lane
    always_comb begin
        case (ex_mem_op)
            op_st_b: ram_wdata = {4{ex_store_data[7:0]}};
            op_st_h: ram_wdata = {2{ex_store_data[15:0]}};
            default: ram_wdata = ex_store_data;
        endcase
    end

    // misaligned accesses are outside the supported set
    always_comb begin
        if (ex_accept && (ex_mem_op == op_ld_h || ex_mem_op == op_ld_hu ||
                          ex_mem_op == op_st_h)) begin
            assert (byte_off[0] == 1'b0)
                else $error("misaligned halfword access at %h", ex_result);
        end
        if (ex_accept && (ex_mem_op == op_ld_w || ex_mem_op == op_st_w)) begin
            assert (byte_off == 2'b00)
                else $error("misaligned word access at %h", ex_result);
        end
    end

endmodule

// File: rtl/data_ram.sv
`timescale 1ns/1ps
`include "lsu_defines.svh"

module data_ram
    import lsu_pkg::*;
(
    input  logic      clk,
    input  logic      ram_en,
    input  logic      ram_we,
    input  ram_addr_t ram_addr,
    input  strb_t     ram_strb,
    input  word_t     ram_wdata,
    output word_t     ram_rdata
);

    word_t mem [`LSU_RAM_DEPTH];

    // byte lane writes
    always_ff @(posedge clk) begin
        if (ram_en && ram_we) begin
            for (int i = 0; i < `LSU_STRB_W; i++) begin
                if (ram_strb[i]) begin
                    mem[ram_addr][8*i +: 8] <= ram_wdata[8*i +: 8];
                end
            end
        end
    end

    // read data only moves on an enabled read, held otherwise
    always_ff @(posedge clk) begin
        if (ram_en && !ram_we) begin
            ram_rdata <= mem[ram_addr];
        end
    end

endmodule

// File: rtl/mem_stage.sv
`timescale 1ns/1ps
`include "lsu_defines.svh"

module mem_stage
    import lsu_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     ex_valid,
    input  word_t    ex_result,
    input  mem_op_t  ex_mem_op,
    input  logic     ex_rf_we,
    input  rf_addr_t ex_rf_waddr,
    input  word_t    ex_pc,
    input  word_t    ram_rdata,
    input  logic     wb_allow_in,
    output logic     mem_allow_in,
    output logic     ex_accept,
    output logic     mem_valid,
    output word_t    mem_pc,
    output logic     mem_rf_we,
    output rf_addr_t mem_rf_waddr,
    output word_t    mem_final,
    output logic     fwd_valid,
    output rf_addr_t fwd_waddr,
    output word_t    fwd_data
);

    word_t   mem_result;
    mem_op_t mem_op;
    logic [7:0]  byte_sel;
    logic [15:0] half_sel;
    word_t   load_value;

    // stage is always ready to go, so it only waits on WB
    assign mem_allow_in = !mem_valid || wb_allow_in;
    assign ex_accept    = ex_valid && mem_allow_in;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mem_valid <= 1'b0;
        end else if (mem_allow_in) begin
            mem_valid <= ex_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (ex_accept) begin
            mem_result   <= ex_result;
            mem_op       <= ex_mem_op;
            mem_rf_we    <= ex_rf_we;
            mem_rf_waddr <= ex_rf_waddr;
            mem_pc       <= ex_pc;
        end
    end

    // lane select by the low address bits
    always_comb begin
        case (mem_result[1:0])
            2'd0:    byte_sel = ram_rdata[7:0];
            2'd1:    byte_sel = ram_rdata[15:8];
            2'd2:    byte_sel = ram_rdata[23:16];
            default: byte_sel = ram_rdata[31:24];
        endcase
    end

    assign half_sel = mem_result[1] ? ram_rdata[31:16] : ram_rdata[15:0];

    always_comb begin
        case (mem_op)
            op_ld_b:  load_value = {{24{byte_sel[7]}}, byte_sel};
            op_ld_bu: load_value = {24'd0, byte_sel};
            op_ld_h:  load_value = {{16{half_sel[15]}}, half_sel};
            op_ld_hu: load_value = {16'd0, half_sel};
            default:  load_value = ram_rdata;
        endcase
    end

    assign mem_final = op_is_load(mem_op) ? load_value : mem_result;

    // bypass toward the execute stage
    assign fwd_valid = mem_valid && mem_rf_we;
    assign fwd_waddr = mem_rf_waddr;
    assign fwd_data  = mem_final;

    // stores never retire with a register write
    a_store_no_write: assert property (
        @(posedge clk) disable iff (!rst_n)
        mem_valid && op_is_store(mem_op) |-> !mem_rf_we
    ) else $error("store in MEM stage carries a register write");

endmodule

// File: rtl/wb_stage.sv
`timescale 1ns/1ps
`include "lsu_defines.svh"

module wb_stage
    import lsu_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     mem_valid,
    input  word_t    mem_pc,
    input  logic     mem_rf_we,
    input  rf_addr_t mem_rf_waddr,
    input  word_t    mem_final,
    input  logic     trace_ready,
    output logic     wb_allow_in,
    output logic     trace_valid,
    output word_t    trace_pc,
    output logic     trace_rf_we,
    output rf_addr_t trace_rf_waddr,
    output word_t    trace_rf_wdata,
    output logic     rf_we,
    output rf_addr_t rf_waddr,
    output word_t    rf_wdata
);

    // free when empty or when the held entry leaves this cycle
    assign wb_allow_in = !trace_valid || trace_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            trace_valid <= 1'b0;
        end else if (wb_allow_in) begin
            trace_valid <= mem_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (mem_valid && wb_allow_in) begin
            trace_pc       <= mem_pc;
            trace_rf_we    <= mem_rf_we;
            trace_rf_waddr <= mem_rf_waddr;
            trace_rf_wdata <= mem_final;
        end
    end

    // write happens once, on the trace handshake
    assign rf_we    = trace_valid && trace_ready && trace_rf_we;
    assign rf_waddr = trace_rf_waddr;
    assign rf_wdata = trace_rf_wdata;

    a_trace_hold: assert property (
        @(posedge clk) disable iff (!rst_n)
        trace_valid && !trace_ready |=>
            trace_valid && $stable(trace_pc) && $stable(trace_rf_we) &&
            $stable(trace_rf_waddr) && $stable(trace_rf_wdata)
    ) else $error("trace entry changed while stalled");

endmodule

// File: rtl/regfile.sv
`timescale 1ns/1ps
`include "lsu_defines.svh"

module regfile
    import lsu_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      rf_we,
    input  logic [`LSU_RF_ADDR_W-1:0] rf_waddr,
    input  word_t                     rf_wdata,
    input  logic [`LSU_RF_ADDR_W-1:0] dbg_raddr,
    output word_t                     dbg_rdata
);

    // r0 has no storage
    word_t regs [1:31];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (rf_we && rf_waddr != '0) begin
            regs[rf_waddr] <= rf_wdata;
        end
    end

    assign dbg_rdata = (dbg_raddr == '0) ? '0 : regs[dbg_raddr];

endmodule

// File: rtl/lsu_top.sv
`timescale 1ns/1ps
`include "lsu_defines.svh"

module lsu_top
    import lsu_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    // execute side
    input  logic     ex_valid,
    input  word_t    ex_result,
    input  word_t    ex_store_data,
    input  mem_op_t  ex_mem_op,
    input  logic     ex_rf_we,
    input  rf_addr_t ex_rf_waddr,
    input  word_t    ex_pc,
    output logic     mem_allow_in,
    // trace
    output logic     trace_valid,
    output word_t    trace_pc,
    output logic     trace_rf_we,
    output rf_addr_t trace_rf_waddr,
    output word_t    trace_rf_wdata,
    input  logic     trace_ready,
    // forwarding
    output logic     fwd_valid,
    output rf_addr_t fwd_waddr,
    output word_t    fwd_data,
    // debug read
    input  rf_addr_t dbg_raddr,
    output word_t    dbg_rdata
);

    logic      ex_accept;
    logic      ram_en;
    logic      ram_we;
    ram_addr_t ram_addr;
    strb_t     ram_strb;
    word_t     ram_wdata;
    word_t     ram_rdata;
    logic      mem_valid;
    word_t     mem_pc;
    logic      mem_rf_we;
    rf_addr_t  mem_rf_waddr;
    word_t     mem_final;
    logic      wb_allow_in;
    logic      rf_we;
    rf_addr_t  rf_waddr;
    word_t     rf_wdata;

    store_unit u_store_unit (
        .ex_accept, .ex_result, .ex_store_data, .ex_mem_op,
        .ram_en, .ram_we, .ram_addr, .ram_strb, .ram_wdata
    );

    data_ram u_data_ram (
        .clk, .ram_en, .ram_we, .ram_addr, .ram_strb, .ram_wdata, .ram_rdata
    );

    mem_stage u_mem_stage (
        .clk, .rst_n, .ex_valid, .ex_result, .ex_mem_op, .ex_rf_we, .ex_rf_waddr, .ex_pc,
        .ram_rdata, .wb_allow_in, .mem_allow_in, .ex_accept, .mem_valid, .mem_pc,
        .mem_rf_we, .mem_rf_waddr, .mem_final, .fwd_valid, .fwd_waddr, .fwd_data
    );

    wb_stage u_wb_stage (
        .clk, .rst_n, .mem_valid, .mem_pc, .mem_rf_we, .mem_rf_waddr, .mem_final,
        .trace_ready, .wb_allow_in, .trace_valid, .trace_pc, .trace_rf_we,
        .trace_rf_waddr, .trace_rf_wdata, .rf_we, .rf_waddr, .rf_wdata
    );

    regfile u_regfile (
        .clk, .rst_n, .rf_we, .rf_waddr, .rf_wdata, .dbg_raddr, .dbg_rdata
    );

endmodule

// File: bench/tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
    parameter int PERIOD_NS    = 40,
    parameter int RESET_CYCLES = 10
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // release a little after an edge, away from the sampling point
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        rst_n = 1'b1;
    end

endmodule

// File: bench/tb_lsu.sv
`timescale 1ns/1ps
`include "lsu_defines.svh"

module tb_lsu
    import lsu_pkg::*;
();

    // about 450 operations of at most 8 cycles each with gaps and stalls
    localparam int    N_OPS       = 450;
    localparam int    CYCLE_LIMIT = N_OPS * 8 + 400;
    localparam word_t SEED        = 32'hf203_0755;

    typedef struct packed {
        word_t    pc;
        logic     we;
        rf_addr_t waddr;
        word_t    data;
    } trace_exp_t;

    logic clk, rst_n, ex_valid, ex_rf_we, mem_allow_in, trace_ready, trace_valid;
    logic trace_rf_we, fwd_valid;
    word_t ex_result, ex_store_data, ex_pc, trace_pc, trace_rf_wdata, fwd_data, dbg_rdata;
    mem_op_t ex_mem_op;
    rf_addr_t ex_rf_waddr, trace_rf_waddr, fwd_waddr, dbg_raddr;

    word_t ram_mirror [`LSU_RAM_DEPTH];
    word_t reg_mirror [32];
    trace_exp_t exp_q [$];
    trace_exp_t exp_new, exp_old, fwd_exp;
    logic fwd_pending, stall_on;
    word_t rnd, rdy_rnd, next_pc;
    word_t addr_q [$];
    string test_name;
    int n_pass, n_fail, fails_at_start, cycles;

    tb_clock u_tb_clock (.clk, .rst_n);

    lsu_top u_lsu_top (
        .clk, .rst_n, .ex_valid, .ex_result, .ex_store_data, .ex_mem_op, .ex_rf_we,
        .ex_rf_waddr, .ex_pc, .mem_allow_in, .trace_valid, .trace_pc, .trace_rf_we,
        .trace_rf_waddr, .trace_rf_wdata, .trace_ready, .fwd_valid, .fwd_waddr,
        .fwd_data, .dbg_raddr, .dbg_rdata
    );

    function automatic word_t xorshift(input word_t s);
        word_t x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // expected final value and RAM mirror update for stores
    function automatic word_t ref_final(input mem_op_t op, input word_t addr,
                                        input word_t sdata);
        ram_addr_t  idx;
        logic [1:0] lane;
        word_t      shifted;
        idx     = addr[`LSU_RAM_ADDR_W+1:2];
        lane    = addr[1:0];
        shifted = ram_mirror[idx] >> {lane, 3'b000};
        case (op)
            op_ld_w:  return ram_mirror[idx];
            op_ld_bu: return shifted & 32'h0000_00ff;
            op_ld_hu: return shifted & 32'h0000_ffff;
            // sign extension by flipping and subtracting the sign bit
            op_ld_b:  return ((shifted & 32'h0000_00ff) ^ 32'h80) - 32'h80;
            op_ld_h:  return ((shifted & 32'h0000_ffff) ^ 32'h8000) - 32'h8000;
            op_st_w:  ram_mirror[idx] = sdata;
            op_st_h:  ram_mirror[idx][{lane, 3'b000} +: 16] = sdata[15:0];
            op_st_b:  ram_mirror[idx][{lane, 3'b000} +: 8] = sdata[7:0];
            default:  ;
        endcase
        return addr;
    endfunction

    task automatic compare_word(input string what, input word_t exp, input word_t act);
        if (act !== exp) begin
            $display("FAILED %s %s expected %h actual %h", test_name, what, exp, act);
            n_fail++;
        end else begin
            n_pass++;
        end
    endtask

    task automatic begin_test(input string name);
        test_name      = name;
        fails_at_start = n_fail;
    endtask

    task automatic end_test();
        if (n_fail == fails_at_start) begin
            $display("test %s: passed", test_name);
        end else begin
            $display("test %s: failed with %0d errors", test_name, n_fail - fails_at_start);
        end
    endtask

    // holds the operation until the MEM stage takes it
    task automatic issue(input mem_op_t op, input word_t result, input word_t sdata,
                         input logic we, input rf_addr_t rd);
        logic taken;
        ex_valid      = 1'b1;
        ex_mem_op     = op;
        ex_result     = result;
        ex_store_data = sdata;
        ex_rf_we      = we;
        ex_rf_waddr   = rd;
        ex_pc         = next_pc;
        next_pc       = next_pc + 4;
        taken         = 1'b0;
        while (!taken) begin
            @(negedge clk);
            taken = mem_allow_in;
            @(posedge clk);
            #2;
        end
        ex_valid = 1'b0;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #2;
        end
    endtask

    task automatic drain();
        do begin
            @(posedge clk);
            #2;
        end while (exp_q.size() != 0);
    endtask

    task automatic check_regs();
        for (int i = 0; i < 32; i++) begin
            dbg_raddr = rf_addr_t'(i);
            #1;
            compare_word($sformatf("r%0d", i), reg_mirror[dbg_raddr], dbg_rdata);
        end
        @(posedge clk);
        #2;
    endtask

    // mid-cycle sampling of forwarding, acceptance and the trace handshake
    always @(negedge clk) begin
        if (rst_n) begin
            if (fwd_pending) begin
                compare_word("fwd_valid", 32'(fwd_exp.we), 32'(fwd_valid));
                if (fwd_exp.we) begin
                    compare_word("fwd_waddr", 32'(fwd_exp.waddr), 32'(fwd_waddr));
                    compare_word("fwd_data", fwd_exp.data, fwd_data);
                end
            end
            fwd_pending = 1'b0;
            if (ex_valid && mem_allow_in) begin
                exp_new.pc    = ex_pc;
                exp_new.we    = ex_rf_we;
                exp_new.waddr = ex_rf_waddr;
                exp_new.data  = ref_final(ex_mem_op, ex_result, ex_store_data);
                exp_q.push_back(exp_new);
                fwd_exp     = exp_new;
                fwd_pending = 1'b1;
            end
            if (trace_valid && trace_ready) begin
                if (exp_q.size() == 0) begin
                    $display("trace handshake at pc %h with no operation outstanding", trace_pc);
                    n_fail++;
                end else begin
                    exp_old = exp_q.pop_front();
                    compare_word("trace_pc", exp_old.pc, trace_pc);
                    compare_word("trace_rf_we", 32'(exp_old.we), 32'(trace_rf_we));
                    compare_word("trace_rf_waddr", 32'(exp_old.waddr), 32'(trace_rf_waddr));
                    compare_word("trace_rf_wdata", exp_old.data, trace_rf_wdata);
                    if (exp_old.we && exp_old.waddr != '0) begin
                        reg_mirror[exp_old.waddr] = exp_old.data;
                    end
                end
            end
        end
    end

    always @(posedge clk) begin
        #2;
        rdy_rnd     = xorshift(rdy_rnd);
        trace_ready = stall_on ? (rdy_rnd % 3 != 0) : 1'b1;
    end

    initial begin
        cycles = 0;
        while (cycles < CYCLE_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: run still busy after %0d cycles", CYCLE_LIMIT);
        $display("RESULT: FAIL");
        $finish;
    end

    initial begin
        mem_op_t    op;
        logic [1:0] lane;
        word_t      addr;
        word_t      r;
        ex_valid = 1'b0;
        ex_result = '0;
        ex_store_data = '0;
        ex_mem_op = op_none;
        ex_rf_we = 1'b0;
        ex_rf_waddr = '0;
        ex_pc = '0;
        trace_ready = 1'b1;
        dbg_raddr = '0;
        foreach (reg_mirror[i]) reg_mirror[i] = '0;
        fwd_pending = 1'b0;
        stall_on = 1'b0;
        rnd = SEED;
        rdy_rnd = SEED;
        next_pc = 32'h1c00_0000;
        n_pass = 0;
        n_fail = 0;
        wait (rst_n === 1'b1);
        @(posedge clk);
        #2;

        begin_test("reset_state");
        compare_word("trace_valid", 0, 32'(trace_valid));
        compare_word("fwd_valid", 0, 32'(fwd_valid));
        compare_word("mem_allow_in", 1, 32'(mem_allow_in));
        check_regs();
        end_test();

        begin_test("word_round_trip");
        for (int i = 0; i < 16; i++) begin
            rnd = xorshift(rnd);
            addr_q.push_back(32'({rnd[`LSU_RAM_ADDR_W-1:0], 2'b00}));
            rnd = xorshift(rnd);
            issue(op_st_w, addr_q[i], rnd, 1'b0, '0);
        end
        foreach (addr_q[i]) issue(op_ld_w, addr_q[i], '0, 1'b1, rf_addr_t'(i + 1));
        drain();
        check_regs();
        end_test();

        begin_test("sub_word_loads");
        issue(op_st_w, 32'h0000_0800, 32'h7f80_c311, 1'b0, '0);
        // bit 7 and bit 15 follow the lane so both signs get extended
        for (int k = 0; k < 4; k++) begin
            rnd = xorshift(rnd);
            issue(op_st_b, 32'h0000_0800 + k, {rnd[31:16], k[1], rnd[14:8], k[0], rnd[6:0]},
                  1'b0, '0);
            issue(op_ld_b, 32'h0000_0800 + k, '0, 1'b1, 5'd1);
            issue(op_ld_bu, 32'h0000_0800 + k, '0, 1'b1, 5'd2);
            issue(op_ld_w, 32'h0000_0800, '0, 1'b1, 5'd3);
        end
        for (int k = 0; k < 4; k += 2) begin
            rnd = xorshift(rnd);
            issue(op_st_h, 32'h0000_0800 + k, {rnd[31:16], k[1], rnd[14:0]}, 1'b0, '0);
            issue(op_ld_h, 32'h0000_0800 + k, '0, 1'b1, 5'd4);
            issue(op_ld_hu, 32'h0000_0800 + k, '0, 1'b1, 5'd5);
            issue(op_ld_w, 32'h0000_0800, '0, 1'b1, 5'd6);
        end
        drain();
        end_test();

        begin_test("non_memory_writes");
        for (int i = 0; i < 8; i++) begin
            rnd = xorshift(rnd);
            issue(op_none, rnd, '0, 1'b1, rf_addr_t'(i * 5));
        end
        drain();
        check_regs();
        end_test();

        begin_test("forwarding");
        for (int i = 0; i < 12; i++) begin
            rnd = xorshift(rnd);
            case (i % 3)
                0:       issue(op_st_w, 32'h0000_0900 + 4 * i, rnd, 1'b0, '0);
                1:       issue(op_ld_w, 32'h0000_0900 + 4 * (i - 1), '0, 1'b1, rf_addr_t'(i));
                default: issue(op_none, rnd, '0, 1'b1, rf_addr_t'(i + 8));
            endcase
        end
        drain();
        end_test();

        begin_test("random_stress");
        for (int w = 0; w < 16; w++) begin
            rnd = xorshift(rnd);
            issue(op_st_w, 32'h0000_0c00 + 4 * w, rnd, 1'b0, '0);
        end
        stall_on = 1'b1;
        for (int n = 0; n < 340; n++) begin
            rnd = xorshift(rnd);
            r   = rnd;
            op  = mem_op_t'(4'(r % 9));
            case (op)
                op_ld_w, op_st_w:           lane = 2'b00;
                op_ld_h, op_ld_hu, op_st_h: lane = {r[9], 1'b0};
                default:                    lane = r[9:8];
            endcase
            addr = 32'h0000_0c00 + 32'({r[7:4], lane});
            rnd  = xorshift(rnd);
            if (op == op_st_w || op == op_st_b || op == op_st_h) begin
                issue(op, addr, rnd, 1'b0, '0);
            end else begin
                issue(op, (op == op_none) ? rnd : addr, '0, 1'b1, r[14:10]);
            end
            if (r[18]) idle_cycles(int'(r[17:16]));
        end
        stall_on = 1'b0;
        drain();
        check_regs();
        end_test();

        $display("checks passed: %0d, checks failed: %0d", n_pass, n_fail);
        if (n_fail == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: build.f
+incdir+include
rtl/lsu_pkg.sv
rtl/store_unit.sv
rtl/data_ram.sv
rtl/mem_stage.sv
rtl/wb_stage.sv
rtl/regfile.sv
rtl/lsu_top.sv
bench/tb_clock.sv
bench/tb_lsu.sv

// File: Makefile
# Verilator build and run for the LSU back end

VERILATOR ?= verilator
TOP       ?= tb_lsu
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST)) $(wildcard include/*.svh)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(SIM_BIN) 2>&1 | tee $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@if ! grep -q "RESULT: PASS" $(LOG); then echo "simulation ended without a result"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
